/* flist.f */
+incdir+dv
common/mango_pkg.sv
common/core_bus_if.sv
common/issue_if.sv
common/retire_if.sv
core/core_fetch_decode.sv
core/core_execute.sv
core/core_result.sv
verilog/mem_arbiter.sv
verilog/mango_top.sv
dv/mango_tb.sv

/* dv/mango_tb_table.svh */
`ifndef mango_tb_table_svh
`define mango_tb_table_svh

// operation kinds of a table row.
localparam logic [3:0] row_addu  = 4'd0;
localparam logic [3:0] row_subu  = 4'd1;
localparam logic [3:0] row_and   = 4'd2;
localparam logic [3:0] row_or    = 4'd3;
localparam logic [3:0] row_xor   = 4'd4;
localparam logic [3:0] row_slt   = 4'd5;
localparam logic [3:0] row_sll   = 4'd6;
localparam logic [3:0] row_addiu = 4'd7;
localparam logic [3:0] row_ori   = 4'd8;
localparam logic [3:0] row_lui   = 4'd9;
localparam logic [3:0] row_lw    = 4'd10;
localparam logic [3:0] row_beq   = 4'd11;
localparam logic [3:0] row_bne   = 4'd12;

typedef struct packed {
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
} row_t;

localparam int n_rows = 17;

// columns: operation, operand a, operand b, branch taken.
// lw rows use a as the load address and b as the word preset there.
localparam row_t tbl [n_rows] = '{
    '{row_addu,  32'h1234_5678, 32'h0fed_cba9, 1'b0},
    '{row_subu,  32'h0000_0005, 32'h0000_0007, 1'b0},
    '{row_and,   32'hf0f0_ff00, 32'h3c3c_0ff0, 1'b0},
    '{row_or,    32'h8000_0101, 32'h0300_a050, 1'b0},
    '{row_xor,   32'hdead_beef, 32'hffff_0000, 1'b0},
    '{row_slt,   32'hffff_fff0, 32'h0000_0003, 1'b0},   // negative vs positive.
    '{row_slt,   32'h0000_0004, 32'hffff_ffff, 1'b0},
    '{row_sll,   32'h8000_0001, 32'h0000_0024, 1'b0},   // only b[4:0] counts.
    '{row_addiu, 32'h0000_1000, 32'h0000_8001, 1'b0},
    '{row_addiu, 32'h7fff_fff0, 32'h0000_0020, 1'b0},
    '{row_ori,   32'h1234_0000, 32'h0000_8765, 1'b0},
    '{row_lui,   32'h0000_0000, 32'h0000_beef, 1'b0},
    '{row_lw,    32'h0000_0300, 32'hcafe_f00d, 1'b0},
    '{row_beq,   32'h0000_0055, 32'h0000_0055, 1'b1},
    '{row_beq,   32'h0000_0005, 32'h0000_0006, 1'b0},
    '{row_bne,   32'h0000_0007, 32'h0000_0008, 1'b1},
    '{row_bne,   32'h0000_0009, 32'h0000_0009, 1'b0}
};

`endif

/* dv/mango_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mango_tb;

    `include "mango_tb_table.svh"

    localparam logic [31:0] reset_pc    = 32'h0000_0800;
    localparam int          cycle_limit = n_rows * 8 * 12;

    // mips opcode and funct encodings.
    localparam logic [5:0] mips_beq   = 6'h04;
    localparam logic [5:0] mips_bne   = 6'h05;
    localparam logic [5:0] mips_addiu = 6'h09;
    localparam logic [5:0] mips_ori   = 6'h0d;
    localparam logic [5:0] mips_lui   = 6'h0f;
    localparam logic [5:0] mips_lw    = 6'h23;
    localparam logic [5:0] mips_sw    = 6'h2b;
    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_slt  = 6'h2a;

    logic        cpu_clk;
    logic        rst_n;
    logic        mem_en;
    logic        mem_wen;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_ready;

    logic [31:0] mem [1024];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    integer      seed;
    int          prog_w;
    int          wait_left;
    logic        in_req;
    logic        first_done;
    int          checks;
    int          value_errors;
    int          other_errors;
    int          stores_seen;
    int          expected_total;
    int          cycles;

    mango_top #(.reset_pc(reset_pc)) dut_i (
        .cpu_clk   (cpu_clk),
        .rst_n     (rst_n),
        .mem_en    (mem_en),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #2 cpu_clk = ~cpu_clk;
    end

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // value of r3 after the row's operation under the mips rules.
    function automatic logic [31:0] expected_result(input logic [3:0] op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        case (op)
            row_addu:  return a + b;
            row_subu:  return a - b;
            row_and:   return a & b;
            row_or:    return a | b;
            row_xor:   return a ^ b;
            row_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            row_sll:   return a << b[4:0];
            row_addiu: return a + {{16{b[15]}}, b[15:0]};
            row_ori:   return a | {16'h0000, b[15:0]};
            row_lui:   return {b[15:0], 16'h0000};
            row_lw:    return b;
            default:   return 32'd0;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_w] = word;
        prog_w++;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // each block loads r1 = a and r2 = b, computes r3, then stores r3.
    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] slot;
        logic [5:0]  op;
        prog_w = reset_pc[11:2];
        for (int i = 0; i < n_rows; i++) begin
            a    = tbl[i].a;
            b    = tbl[i].b;
            slot = 16'h0100 + 16'(4 * i);
            emit(i_type(mips_lui, 5'd0, 5'd1, a[31:16]));
            emit(i_type(mips_ori, 5'd1, 5'd1, a[15:0]));
            emit(i_type(mips_lui, 5'd0, 5'd2, b[31:16]));
            emit(i_type(mips_ori, 5'd2, 5'd2, b[15:0]));
            case (tbl[i].op)
                row_addu:  emit(r_type(5'd1, 5'd2, 5'd3, 5'd0, funct_addu));
                row_subu:  emit(r_type(5'd1, 5'd2, 5'd3, 5'd0, funct_subu));
                row_and:   emit(r_type(5'd1, 5'd2, 5'd3, 5'd0, funct_and));
                row_or:    emit(r_type(5'd1, 5'd2, 5'd3, 5'd0, funct_or));
                row_xor:   emit(r_type(5'd1, 5'd2, 5'd3, 5'd0, funct_xor));
                row_slt:   emit(r_type(5'd1, 5'd2, 5'd3, 5'd0, funct_slt));
                row_sll:   emit(r_type(5'd0, 5'd1, 5'd3, b[4:0], funct_sll));
                row_addiu: emit(i_type(mips_addiu, 5'd1, 5'd3, b[15:0]));
                row_ori:   emit(i_type(mips_ori, 5'd1, 5'd3, b[15:0]));
                row_lui:   emit(i_type(mips_lui, 5'd0, 5'd3, b[15:0]));
                row_lw: begin
                    mem[a[11:2]] = b;   // preset word for the load.
                    emit(i_type(mips_lw, 5'd1, 5'd3, 16'h0000));
                end
                default: begin
                    op = (tbl[i].op == row_beq) ? mips_beq : mips_bne;
                    emit(i_type(mips_addiu, 5'd0, 5'd3, 16'(i)));
                    emit(i_type(op, 5'd1, 5'd2, 16'h0001));   // skips the poison store.
                    emit(i_type(mips_sw, 5'd0, 5'd3, 16'h0200));
                    if (!tbl[i].taken) begin
                        exp_addr_q.push_back(32'h0000_0200);
                        exp_data_q.push_back(32'(i));
                    end
                end
            endcase
            emit(i_type(mips_sw, 5'd0, 5'd3, slot));
            exp_addr_q.push_back({16'h0000, slot});
            if (tbl[i].op == row_beq || tbl[i].op == row_bne)
                exp_data_q.push_back(32'(i));
            else
                exp_data_q.push_back(expected_result(tbl[i].op, a, b));
        end
        emit(i_type(mips_beq, 5'd0, 5'd0, 16'hffff));   // park in a self loop.
    endtask

    task automatic handle_store();
        logic [31:0] ea;
        logic [31:0] ed;
        stores_seen++;
        if (exp_addr_q.size() == 0) begin
            other_errors++;
            $display("store of %h to %h arrived after all expected stores", mem_wdata, mem_addr);
        end else begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            check_value("mem_addr", ea, mem_addr);
            check_value("mem_wdata", ed, mem_wdata);
        end
    endtask

    // memory model that answers each request after 0 to 3 cycles.
    always @(negedge cpu_clk) begin
        if (mem_ready)
            in_req = 1'b0;   // that transfer finished on the rising edge.
        mem_ready = 1'b0;
        if (!rst_n) begin
            check_value("mem_en", 32'd0, {31'd0, mem_en});
        end else if (mem_en === 1'b1) begin
            if (!first_done) begin
                first_done = 1'b1;
                check_value("mem_wen", 32'd0, {31'd0, mem_wen});
                check_value("mem_addr", reset_pc, mem_addr);
            end
            if (!in_req) begin
                in_req    = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                if (mem_wen) begin
                    handle_store();
                    mem[mem_addr[11:2]] = mem_wdata;
                end else begin
                    mem_rdata = mem[mem_addr[11:2]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        seed         = 85948;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        stores_seen  = 0;
        cycles       = 0;
        in_req       = 1'b0;
        first_done   = 1'b0;
        wait_left    = 0;
        rst_n        = 1'b0;
        mem_rdata    = '0;
        mem_ready    = 1'b0;
        for (int k = 0; k < 1024; k++)
            mem[k] = 32'h6b00_0000 | (k << 2);   // unsupported opcode that decodes as a nop.
        build_program();
        expected_total = exp_addr_q.size();
        repeat (10) @(negedge cpu_clk);
        rst_n = 1'b1;
        while (exp_addr_q.size() != 0 && cycles < cycle_limit) begin
            @(posedge cpu_clk);
            cycles++;
        end
        if (exp_addr_q.size() != 0) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d of %0d stores still missing",
                     cycles, exp_addr_q.size(), expected_total);
        end
        repeat (40) @(posedge cpu_clk);   // room for any stray store.
        check_value("store count", expected_total, stores_seen);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mango_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mango_top import mango_pkg::*; #(
    parameter logic [addr_w-1:0] reset_pc = '0
) (
    input  logic              cpu_clk,
    input  logic              rst_n,
    output logic              mem_en,
    output logic              mem_wen,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata,
    input  logic [data_w-1:0] mem_rdata,
    input  logic              mem_ready
);

    logic              rst_meta;
    logic              core_rst_n;
    logic              redirect;
    logic [addr_w-1:0] redirect_pc;
    logic              wb_en;
    logic [4:0]        wb_reg;
    logic [data_w-1:0] wb_data;
    logic              result_busy;

    // async assert, release two clocks later.
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_meta   <= 1'b0;
            core_rst_n <= 1'b0;
        end else begin
            rst_meta   <= 1'b1;
            core_rst_n <= rst_meta;
        end
    end

    core_bus_if ibus ();
    core_bus_if dbus ();
    issue_if    issue ();
    retire_if   retire ();

    core_fetch_decode #(.reset_pc(reset_pc)) u_fetch_decode (
        .cpu_clk     (cpu_clk),
        .rst_n       (core_rst_n),
        .ibus        (ibus.master),
        .issue       (issue.master),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .result_busy (result_busy)
    );

    core_execute u_execute (
        .cpu_clk     (cpu_clk),
        .rst_n       (core_rst_n),
        .issue       (issue.slave),
        .retire      (retire.master),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    core_result u_result (
        .cpu_clk     (cpu_clk),
        .rst_n       (core_rst_n),
        .retire      (retire.slave),
        .dbus        (dbus.master),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .result_busy (result_busy)
    );

    mem_arbiter u_arbiter (
        .cpu_clk   (cpu_clk),
        .rst_n     (core_rst_n),
        .ibus      (ibus.slave),
        .dbus      (dbus.slave),
        .mem_en    (mem_en),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import mango_pkg::*; (
    input  logic              cpu_clk,
    input  logic              rst_n,
    core_bus_if.slave         ibus,
    core_bus_if.slave         dbus,
    output logic              mem_en,
    output logic              mem_wen,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata,
    input  logic [data_w-1:0] mem_rdata,
    input  logic              mem_ready
);

    logic gnt_v;   // a transfer is waiting for mem_ready.
    logic gnt_d;
    logic sel_d;

    // a held grant wins, otherwise data goes first.
    assign sel_d = gnt_v ? gnt_d : dbus.en;

    assign mem_en    = sel_d ? dbus.en    : ibus.en;
    assign mem_wen   = sel_d ? dbus.wen   : ibus.wen;
    assign mem_addr  = sel_d ? dbus.addr  : ibus.addr;
    assign mem_wdata = sel_d ? dbus.wdata : ibus.wdata;

    assign ibus.rdata = mem_rdata;
    assign dbus.rdata = mem_rdata;
    assign ibus.stall = sel_d || !mem_ready;
    assign dbus.stall = !sel_d || !mem_ready;

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_v <= 1'b0;
            gnt_d <= 1'b0;
        end else if (mem_en && mem_ready) begin
            gnt_v <= 1'b0;
        end else if (mem_en) begin
            gnt_v <= 1'b1;
            gnt_d <= sel_d;
        end
    end

endmodule

`default_nettype wire

/* core/core_result.sv */
`timescale 1ns/100ps
`default_nettype none

module core_result import mango_pkg::*; (
    input  logic              cpu_clk,
    input  logic              rst_n,
    retire_if.slave           retire,
    core_bus_if.master        dbus,
    output logic              wb_en,
    output logic [4:0]        wb_reg,
    output logic [data_w-1:0] wb_data,
    output logic              result_busy
);

    logic              busy;
    logic              req_load;
    logic [addr_w-1:0] req_addr;
    logic [data_w-1:0] req_wdata;
    logic              done;
    logic              is_mem;

    assign is_mem      = retire.is_load || retire.is_store;
    assign dbus.en     = busy;
    assign dbus.wen    = busy && !req_load;
    assign dbus.addr   = req_addr;
    assign dbus.wdata  = req_wdata;
    assign done        = busy && !dbus.stall;
    assign result_busy = busy;

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            wb_en <= 1'b0;
        end else begin
            wb_en <= (retire.valid && !is_mem) || (done && req_load);
            if (retire.valid && is_mem)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
        end
    end

    // wb_reg stays put across a load, decode issues nothing meanwhile.
    always_ff @(posedge cpu_clk) begin
        if (retire.valid) begin
            req_addr  <= retire.value;
            req_wdata <= retire.store_data;
            req_load  <= retire.is_load;
            wb_reg    <= retire.dest;
            wb_data   <= retire.value;
        end else if (done) begin
            wb_data <= dbus.rdata;
        end
    end

endmodule

`default_nettype wire

/* core/core_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module core_execute import mango_pkg::*; (
    input  logic              cpu_clk,
    input  logic              rst_n,
    issue_if.slave            issue,
    retire_if.master          retire,
    output logic              redirect,
    output logic [addr_w-1:0] redirect_pc
);

    logic [data_w-1:0] b_ext;
    logic [data_w-1:0] alu_res;
    logic              taken;

    // immediate adds (addiu, lw, sw) sign-extend; ori and lui take the field as is.
    assign b_ext = (issue.imm_sel && issue.alu_op == alu_add) ?
                   {{16{issue.b[15]}}, issue.b[15:0]} : issue.b;

    always_comb begin
        case (issue.alu_op)
            alu_add: alu_res = issue.a + b_ext;
            alu_sub: alu_res = issue.a - b_ext;
            alu_and: alu_res = issue.a & b_ext;
            alu_or:  alu_res = issue.a | b_ext;
            alu_xor: alu_res = issue.a ^ b_ext;
            alu_slt: alu_res = {31'd0, $signed(issue.a) < $signed(b_ext)};
            alu_sll: alu_res = issue.a << b_ext[4:0];
            alu_lui: alu_res = {b_ext[15:0], 16'd0};
            default: alu_res = '0;
        endcase
    end

    assign taken = issue.is_branch && ((issue.a == issue.b) ^ issue.branch_ne);

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            retire.valid <= 1'b0;
            redirect     <= 1'b0;
        end else begin
            retire.valid <= issue.valid && !issue.is_branch;   // branches retire nothing.
            redirect     <= issue.valid && taken;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (issue.valid) begin
            retire.value      <= alu_res;
            retire.is_load    <= issue.is_load;
            retire.is_store   <= issue.is_store;
            retire.dest       <= issue.dest;
            retire.store_data <= issue.store_data;
            redirect_pc       <= issue.branch_target;
        end
    end

endmodule

`default_nettype wire

/* core/core_fetch_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module core_fetch_decode import mango_pkg::*; #(
    parameter logic [addr_w-1:0] reset_pc = '0
) (
    input  logic              cpu_clk,
    input  logic              rst_n,
    core_bus_if.master        ibus,
    issue_if.master           issue,
    input  logic              redirect,
    input  logic [addr_w-1:0] redirect_pc,
    input  logic              wb_en,
    input  logic [4:0]        wb_reg,
    input  logic [data_w-1:0] wb_data,
    input  logic              result_busy
);

    logic              run;
    logic [addr_w-1:0] pc;          // next fetch address; buffered word + 4 while buf_v.
    logic [addr_w-1:0] pend_pc;
    logic              drop;        // discard the fetch still in flight.
    logic              buf_v;
    instr_word_u       buf_word;
    logic [data_w-1:0] rf [32];
    logic [data_w-1:0] rs_val;
    logic [data_w-1:0] rt_val;
    logic              fetch_done;
    logic              ex_v;
    logic              ex_mem;
    logic [4:0]        ex_dest;
    logic              hazard;
    logic              hold;
    logic              issue_go;
    logic [3:0]        d_alu;
    logic [data_w-1:0] d_a;
    logic [data_w-1:0] d_b;
    logic              d_imm;
    logic [4:0]        d_dest;
    logic              d_load;
    logic              d_store;
    logic              d_branch;
    logic              d_ne;

    assign ibus.en    = run && !buf_v;
    assign ibus.wen   = 1'b0;
    assign ibus.addr  = pc;
    assign ibus.wdata = '0;
    assign fetch_done = ibus.en && !ibus.stall;

    // writeback bypasses the array read.
    assign rs_val = (buf_word.r_fields.rs == 5'd0) ? '0 :
                    (wb_en && wb_reg == buf_word.r_fields.rs) ? wb_data :
                    rf[buf_word.r_fields.rs];
    assign rt_val = (buf_word.r_fields.rt == 5'd0) ? '0 :
                    (wb_en && wb_reg == buf_word.r_fields.rt) ? wb_data :
                    rf[buf_word.r_fields.rt];

    always_comb begin
        hazard = 1'b0;
        for (int s = 0; s < 2; s++) begin
            logic [4:0] src;
            src = (s == 0) ? buf_word.r_fields.rs : buf_word.r_fields.rt;
            if (src != 5'd0 && ((issue.valid && issue.dest == src) || (ex_v && ex_dest == src)))
                hazard = 1'b1;
        end
    end

    // branches resolve before the next issue; memory ops drain through result.
    assign hold = (issue.valid && (issue.is_branch || issue.is_load || issue.is_store)) || ex_mem;
    assign issue_go = buf_v && !redirect && !result_busy && !hazard && !hold;

    always_comb begin
        d_alu    = alu_add;
        d_a      = rs_val;
        d_b      = rt_val;
        d_imm    = 1'b0;
        d_dest   = 5'd0;
        d_load   = 1'b0;
        d_store  = 1'b0;
        d_branch = 1'b0;
        d_ne     = 1'b0;
        case (buf_word.r_fields.op)
            op_special: begin
                d_dest = buf_word.r_fields.rd;
                case (buf_word.r_fields.funct)
                    fn_addu: d_alu = alu_add;
                    fn_subu: d_alu = alu_sub;
                    fn_and:  d_alu = alu_and;
                    fn_or:   d_alu = alu_or;
                    fn_xor:  d_alu = alu_xor;
                    fn_slt:  d_alu = alu_slt;
                    fn_sll: begin
                        d_alu = alu_sll;
                        d_a   = rt_val;
                        d_b   = {27'd0, buf_word.r_fields.shamt};
                        d_imm = 1'b1;
                    end
                    default: d_dest = 5'd0;   // unsupported funct runs as a nop.
                endcase
            end
            op_addiu, op_ori, op_lui, op_lw, op_sw: begin
                d_b     = {16'd0, buf_word.i_fields.imm};
                d_imm   = 1'b1;
                d_dest  = (buf_word.i_fields.op == op_sw) ? 5'd0 : buf_word.i_fields.rt;
                d_load  = (buf_word.i_fields.op == op_lw);
                d_store = (buf_word.i_fields.op == op_sw);
                if (buf_word.i_fields.op == op_ori)
                    d_alu = alu_or;
                else if (buf_word.i_fields.op == op_lui)
                    d_alu = alu_lui;
            end
            op_beq, op_bne: begin
                d_branch = 1'b1;
                d_ne     = (buf_word.i_fields.op == op_bne);
            end
            default: ;
        endcase
    end

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            run         <= 1'b0;
            pc          <= reset_pc;
            pend_pc     <= reset_pc;
            drop        <= 1'b0;
            buf_v       <= 1'b0;
            issue.valid <= 1'b0;
            ex_v        <= 1'b0;
            ex_mem      <= 1'b0;
            ex_dest     <= 5'd0;
        end else begin
            run <= 1'b1;
            if (redirect) begin
                buf_v <= 1'b0;
                if (ibus.en && ibus.stall) begin
                    drop    <= 1'b1;   // request must be held, so let it finish.
                    pend_pc <= redirect_pc;
                end else begin
                    pc <= redirect_pc;
                end
            end else if (fetch_done) begin
                if (drop) begin
                    drop <= 1'b0;
                    pc   <= pend_pc;
                end else begin
                    buf_v <= 1'b1;
                    pc    <= pc + 32'd4;
                end
            end else if (issue_go) begin
                buf_v <= 1'b0;
            end
            issue.valid <= issue_go;
            ex_v        <= issue.valid;
            ex_mem      <= issue.valid && (issue.is_load || issue.is_store);
            ex_dest     <= issue.dest;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (fetch_done)
            buf_word <= ibus.rdata;
        if (wb_en && wb_reg != 5'd0)
            rf[wb_reg] <= wb_data;
    end

    always_ff @(posedge cpu_clk) begin
        if (issue_go) begin
            issue.alu_op     <= d_alu;
            issue.a          <= d_a;
            issue.b          <= d_b;
            issue.imm_sel    <= d_imm;
            issue.dest       <= d_dest;
            issue.is_load    <= d_load;
            issue.is_store   <= d_store;
            issue.is_branch  <= d_branch;
            issue.branch_ne  <= d_ne;
            issue.store_data <= rt_val;
            // pc already points one word past the branch.
            issue.branch_target <= pc + {{14{buf_word.i_fields.imm[15]}},
                                         buf_word.i_fields.imm, 2'b00};
        end
    end

endmodule

`default_nettype wire

/* common/retire_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface retire_if import mango_pkg::*; ();

    logic              valid;
    logic [data_w-1:0] value;      // alu result, or the address for load/store.
    logic              is_load;
    logic              is_store;
    logic [4:0]        dest;
    logic [data_w-1:0] store_data;

    modport master (
        output valid, value, is_load, is_store, dest, store_data
    );

    modport slave (
        input  valid, value, is_load, is_store, dest, store_data
    );

endinterface

`default_nettype wire

/* common/issue_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface issue_if import mango_pkg::*; ();

    logic              valid;          // one pulse per instruction.
    logic [3:0]        alu_op;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic              imm_sel;        // b holds the raw immediate field.
    logic [4:0]        dest;           // zero when nothing is written back.
    logic              is_load;
    logic              is_store;
    logic              is_branch;
    logic              branch_ne;
    logic [data_w-1:0] store_data;
    logic [addr_w-1:0] branch_target;

    modport master (output valid, alu_op, a, b, imm_sel, dest, is_load, is_store,
                    is_branch, branch_ne, store_data, branch_target);
    modport slave (input valid, alu_op, a, b, imm_sel, dest, is_load, is_store,
                   is_branch, branch_ne, store_data, branch_target);

endinterface

`default_nettype wire

/* common/core_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one request at a time; done in the cycle with en high and stall low.
interface core_bus_if import mango_pkg::*; ();

    logic              en;
    logic              wen;     // high for a write.
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] rdata;   // valid in the completion cycle.
    logic              stall;

    modport master (
        output en, wen, addr, wdata,
        input  rdata, stall
    );

    modport slave (
        input  en, wen, addr, wdata,
        output rdata, stall
    );

endinterface

`default_nettype wire

/* common/mango_pkg.sv */
`default_nettype none

package mango_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    // primary opcodes of the supported subset.
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct codes under op_special.
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    // internal alu operation, carried from decode to execute.
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_xor = 4'd4;
    localparam logic [3:0] alu_slt = 4'd5;
    localparam logic [3:0] alu_sll = 4'd6;
    localparam logic [3:0] alu_lui = 4'd7;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_word_u;

endpackage

`default_nettype wire
